// ==== Bender.yml ====
package:
  name: srpt_grant

sources:
  - include_dirs:
      - .
    files:
      - srpt_pkg.sv
      - srpt_sort_stage.sv
      - srpt_main_queue.sv
      - srpt_active_set.sv
      - srpt_grant_ctrl.sv
      - srpt_grant_top.sv
      - target: test
        include_dirs:
          - .
        files:
          - srpt_grant_assert.sv
          - srpt_grant_tb.sv

// ==== files.f ====
+incdir+.
srpt_pkg.sv
srpt_sort_stage.sv
srpt_main_queue.sv
srpt_active_set.sv
srpt_grant_ctrl.sv
srpt_grant_top.sv
srpt_grant_assert.sv
srpt_grant_tb.sv

// ==== srpt_active_set.sv ====
`timescale 1ns/1ps
`include "srpt_settings.svh"

module srpt_active_set #(
   parameter int SLOTS = `SRPT_OVERCOMMIT
) (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  srpt_pkg::queue_op_e   op_i,
   input  srpt_pkg::srpt_entry_t main_head_i,
   output srpt_pkg::srpt_entry_t head_o,
   output srpt_pkg::srpt_entry_t tail_o
);
   import srpt_pkg::*;

   // Active slots, index 0 is the next grant candidate
   srpt_entry_t slot_q [SLOTS];

   // Slots after one transposition pass
   srpt_entry_t sorted [SLOTS];

   // Sort phase of this set, independent of the main queue
   logic odd_phase_q;

   srpt_sort_stage #(
      .N(SLOTS)
   ) sort_stage_i (
      .entries_i  (slot_q),
      .odd_phase_i(odd_phase_q),
      .entries_o  (sorted)
   );

   // Head feeds the grant decision
   assign head_o = slot_q[0];

   // Tail is compared against the main queue head
   // and is handed back to the main queue on a promote
   assign tail_o = slot_q[SLOTS-1];

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         odd_phase_q <= 1'b0;
         // Nothing active after reset
         for (int i = 0; i < SLOTS; i++) begin
            slot_q[i] <= EMPTY_ENTRY;
         end
      end else begin
         case (op_i)
            PROMOTE: begin
               // Main head beats the tail, swap it in
               slot_q[SLOTS-1] <= main_head_i;
            end
            GRANT: begin
               // Message granted in full, its slot is free again
               slot_q[0] <= EMPTY_ENTRY;
            end
            default: begin
               // SORT and INSERT leave the set free for a sort pass
               slot_q      <= sorted;
               odd_phase_q <= ~odd_phase_q;
            end
         endcase
      end
   end

   // Free slots sink to the tail over the next sort passes
   // and are then refilled by promotes from the main queue
   // Entries swapped in at the tail rise
   // until they meet a better one

endmodule

// ==== srpt_grant_assert.sv ====
`timescale 1ns/1ps

module srpt_grant_assert (
   input logic ap_clk,
   input logic ap_rst,
   input logic header_empty_i,
   input logic header_rd_i,
   input logic grant_full_i,
   input logic grant_wr_i
);

   // Number of failed assertions
   int fail_cnt = 0;

   // One pop per sampled header
   rd_single_pulse: assert property (@(posedge ap_clk) disable iff (ap_rst)
      header_rd_i |=> !header_rd_i)
      else begin
         fail_cnt++;
         $error("header_rd_o high on two consecutive cycles");
      end

   // A pop needs a header that was there the cycle before
   rd_after_valid: assert property (@(posedge ap_clk) disable iff (ap_rst)
      $rose(header_rd_i) |-> $past(!header_empty_i))
      else begin
         fail_cnt++;
         $error("header_rd_o rose without a valid header");
      end

   // Grants only when the grant FIFO had room at decision time
   wr_after_room: assert property (@(posedge ap_clk) disable iff (ap_rst)
      $rose(grant_wr_i) |-> $past(!grant_full_i))
      else begin
         fail_cnt++;
         $error("grant_wr_o rose after a full grant FIFO");
      end

   // Outputs low through reset
   quiet_in_reset: assert property (@(posedge ap_clk)
      ap_rst |=> (!header_rd_i && !grant_wr_i))
      else begin
         fail_cnt++;
         $error("FIFO strobes active during reset");
      end

endmodule

// ==== srpt_grant_ctrl.sv ====
`timescale 1ns/1ps
`include "srpt_settings.svh"

module srpt_grant_ctrl (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  header_empty_i,
   input  srpt_pkg::srpt_hdr_t   header_data_i,
   output logic                  header_rd_o,
   input  logic                  grant_full_i,
   output logic                  grant_wr_o,
   output srpt_pkg::srpt_entry_t grant_data_o,
   input  srpt_pkg::srpt_entry_t main_head_i,
   input  srpt_pkg::srpt_entry_t act_head_i,
   input  srpt_pkg::srpt_entry_t act_tail_i,
   output srpt_pkg::queue_op_e   op_o,
   output srpt_pkg::srpt_entry_t new_entry_o
);
   import srpt_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_d;

   // Header sampled in this IDLE cycle
   logic hdr_take;
   // Header opens a new message with packets left to grant
   logic hdr_insert;
   logic promote_ok;
   logic grant_ok;

   assign hdr_take = (state_q == IDLE) && !header_empty_i;

   // Only the first packet creates an entry, later offsets are dropped
   assign hdr_insert = hdr_take && (header_data_i.offset == '0)
                       && (header_data_i.msg_len > header_data_i.incoming);

   // No swap while a header is taken or right after a swap
   assign promote_ok = !hdr_take && (state_q != QUEUE_SWAP)
                       && ranks_before(main_head_i, act_tail_i);

   // Head must be live, have received packets and find room downstream
   assign grant_ok = (act_head_i.state == ACTIVE) && (act_head_i.recv_pkts != '0)
                     && !grant_full_i;

   // Entry built straight from the header on the FIFO output
   always_comb begin
      new_entry_o.peer_id    = header_data_i.peer_id;
      new_entry_o.rpc_id     = header_data_i.rpc_id;
      new_entry_o.recv_pkts  = `SRPT_PKTS_W'(1);
      new_entry_o.grant_pkts = header_data_i.msg_len - `SRPT_PKTS_W'(1);
      new_entry_o.state      = ACTIVE;
   end

   // Fixed priority, one operation per cycle
   always_comb begin
      if (hdr_insert) begin
         op_o = INSERT;
      end else if (promote_ok) begin
         op_o = PROMOTE;
      end else if (grant_ok) begin
         op_o = GRANT;
      end else begin
         op_o = SORT;
      end
   end

   // Next state
   always_comb begin
      state_d = IDLE;
      case (state_q)
         IDLE: begin
            if (hdr_take) begin
               state_d = NEW_HDR;
            end else if (op_o == PROMOTE) begin
               state_d = QUEUE_SWAP;
            end
         end
         NEW_HDR: begin
            // Header pops on this edge, a swap may still start here
            if (op_o == PROMOTE) begin
               state_d = QUEUE_SWAP;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         state_q     <= IDLE;
         header_rd_o <= 1'b0;
         grant_wr_o  <= 1'b0;
      end else begin
         state_q     <= state_d;
         // Pop one cycle after sampling
         header_rd_o <= hdr_take;
         grant_wr_o  <= (op_o == GRANT);
      end
   end

   // Granted head leaves with the write pulse
   always_ff @(posedge ap_clk) begin
      if (op_o == GRANT) begin
         grant_data_o <= act_head_i;
      end
   end

endmodule

// ==== srpt_grant_tb.sv ====
`timescale 1ns/1ps
`include "srpt_settings.svh"

module srpt_grant_tb;
   import srpt_pkg::*;

   localparam int ROWS      = 26;
   localparam int SETTLE    = 20;
   localparam int IDLE_WAIT = 50;
   localparam int FULL_WAIT = 4 * (`SRPT_MAIN_DEPTH + `SRPT_OVERCOMMIT);
   // 40 cycles per row plus every fixed wait and the reset
   localparam int LIMIT     = ROWS * 40 + IDLE_WAIT + FULL_WAIT + 5 * SETTLE + 2;
   // Unsorted message lengths for the back-pressure test
   localparam int FULL_LENS [10] = '{40, 12, 97, 25, 6, 63, 18, 150, 31, 9};

   typedef logic [`SRPT_PEER_W-1:0] peer_t;
   typedef logic [`SRPT_RPC_W-1:0]  rpc_t;
   typedef logic [`SRPT_PKTS_W-1:0] pkts_t;

   // Stimulus row with its expected outcome
   typedef struct {
      int    test;
      peer_t peer;
      rpc_t  rpc;
      pkts_t len;
      pkts_t inc;
      pkts_t off;
      bit    grant;
   } row_t;

   logic        ap_clk;
   logic        ap_rst;
   logic        header_empty_i;
   srpt_hdr_t   header_data_i;
   logic        header_rd_o;
   logic        grant_full_i;
   logic        grant_wr_o;
   srpt_entry_t grant_data_o;

   row_t        rows [ROWS];
   srpt_hdr_t   hdr_fifo [$];
   srpt_entry_t got_q [$];
   srpt_entry_t exp_q [$];
   int          rd_cnt;
   int          cycle_cnt;
   int          errors;
   int          failed_tests;
   int          assert_seen;

   srpt_grant_top srpt_grant_top_i (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .header_empty_i(header_empty_i),
      .header_data_i (header_data_i),
      .header_rd_o   (header_rd_o),
      .grant_full_i  (grant_full_i),
      .grant_wr_o    (grant_wr_o),
      .grant_data_o  (grant_data_o)
   );

   bind srpt_grant_top srpt_grant_assert srpt_grant_assert_i (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .header_empty_i(header_empty_i),
      .header_rd_i   (header_rd_o),
      .grant_full_i  (grant_full_i),
      .grant_wr_i    (grant_wr_o)
   );

   initial begin
      ap_clk = 1'b0;
      forever #50 ap_clk = ~ap_clk;
   end

   // Header FIFO model with the first word falling through
   // Grant FIFO model just records every write
   always @(posedge ap_clk) begin
      if (header_rd_o === 1'b1 && hdr_fifo.size() > 0) begin
         void'(hdr_fifo.pop_front());
         rd_cnt++;
      end
      header_empty_i <= (hdr_fifo.size() == 0);
      if (hdr_fifo.size() > 0) begin
         header_data_i <= hdr_fifo[0];
      end
      if (grant_wr_o === 1'b1) begin
         got_q.push_back(grant_data_o);
      end
   end

   // Watchdog
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < LIMIT) begin
         @(posedge ap_clk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("=== FAIL ===");
      $finish;
   end

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic load_table();
      rows[0] = '{2, 14'h00a1, 14'h0123, 10'd8, 10'd1, 10'd0, 1'b1};
      // Later packet, length equal to incoming, length below incoming
      rows[1] = '{3, 14'h00b2, 14'h0200, 10'd12, 10'd2, 10'd4, 1'b0};
      rows[2] = '{3, 14'h00b3, 14'h0201, 10'd5, 10'd5, 10'd0, 1'b0};
      rows[3] = '{3, 14'h00b4, 14'h0202, 10'd3, 10'd9, 10'd0, 1'b0};
      for (int k = 0; k < 10; k++) begin
         rows[4+k] = '{4, peer_t'(16'h100 + k), rpc_t'(16'h300 + k),
                       pkts_t'(FULL_LENS[k]), pkts_t'(2), pkts_t'(0), 1'b1};
      end
      for (int k = 14; k < ROWS; k++) begin
         rows[k].test = 5;
         rows[k].peer = peer_t'($urandom);
         rows[k].rpc  = rpc_t'($urandom);
         rows[k].len  = pkts_t'(2 + $urandom % 300);
         rows[k].inc  = pkts_t'($urandom % 4);
         rows[k].off  = ($urandom % 4 == 0) ? pkts_t'(1 + $urandom % 20) : pkts_t'(0);
         // Only a first packet with packets left earns a grant
         rows[k].grant = (rows[k].off == '0) && (rows[k].len > rows[k].inc);
      end
   endtask

   // Insertion sort by grantable packets or by the whole entry
   task automatic sort_entries(ref srpt_entry_t q[$], input bit by_len);
      srpt_entry_t tmp;
      int          j;
      for (int i = 1; i < q.size(); i++) begin
         tmp = q[i];
         j = i;
         while (j > 0 && (by_len ? (q[j-1].grant_pkts > tmp.grant_pkts) : (q[j-1] > tmp))) begin
            q[j] = q[j-1];
            j--;
         end
         q[j] = tmp;
      end
   endtask

   // Bounded wait for header pops and grants
   task automatic wait_done(input int reads, input int grants, input int limit,
                            input bit random_full);
      int waited;
      waited = 0;
      while ((rd_cnt < reads || got_q.size() < grants) && waited < limit) begin
         @(posedge ap_clk);
         if (random_full) begin
            grant_full_i <= 1'($urandom % 2);
         end
         @(negedge ap_clk);
         waited++;
      end
      if (rd_cnt < reads || got_q.size() < grants) begin
         $display("Timed out after %0d cycles waiting for header pops or grants", limit);
         errors++;
      end
   endtask

   task automatic run_test(input int test, input bit hold_full, input bit random_full);
      srpt_hdr_t   hdr;
      srpt_entry_t ent;
      int          rd_start;
      int          n_rd;
      int          errs_before;
      errs_before = errors;
      got_q.delete();
      exp_q.delete();
      if (hold_full) begin
         @(posedge ap_clk);
         grant_full_i <= 1'b1;
      end
      @(negedge ap_clk);
      rd_start = rd_cnt;
      n_rd = rd_cnt;
      foreach (rows[i]) begin
         if (rows[i].test == test) begin
            hdr.peer_id  = rows[i].peer;
            hdr.rpc_id   = rows[i].rpc;
            hdr.msg_len  = rows[i].len;
            hdr.incoming = rows[i].inc;
            hdr.offset   = rows[i].off;
            hdr_fifo.push_back(hdr);
            n_rd++;
            if (rows[i].grant) begin
               ent.peer_id    = rows[i].peer;
               ent.rpc_id     = rows[i].rpc;
               ent.recv_pkts  = pkts_t'(1);
               ent.grant_pkts = rows[i].len - pkts_t'(1);
               ent.state      = ACTIVE;
               exp_q.push_back(ent);
            end
         end
      end
      // No headers so only watch the idle DUT
      if (n_rd == rd_start) begin
         repeat (IDLE_WAIT) @(negedge ap_clk);
      end
      if (hold_full) begin
         wait_done(n_rd, 0, 40 * (n_rd - rd_start + 1), 1'b0);
         repeat (FULL_WAIT) @(negedge ap_clk);
         compare("grant_wr_o count under full", 64'(got_q.size()), 64'd0);
         @(posedge ap_clk);
         grant_full_i <= 1'b0;
      end
      wait_done(n_rd, exp_q.size(), 40 * (n_rd - rd_start + 1), random_full);
      @(posedge ap_clk);
      grant_full_i <= 1'b0;
      repeat (SETTLE) @(negedge ap_clk);
      compare("header_rd_o count", 64'(rd_cnt), 64'(n_rd));
      compare("grant_wr_o count", 64'(got_q.size()), 64'(exp_q.size()));
      // Back-pressure grants keep arrival order while the rest compare as sets
      if (hold_full) begin
         sort_entries(exp_q, 1'b1);
      end else begin
         sort_entries(exp_q, 1'b0);
         sort_entries(got_q, 1'b0);
      end
      for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
         compare($sformatf("grant_data_o[%0d]", i), 64'(got_q[i]), 64'(exp_q[i]));
      end
      // Assertion failures during this test count as errors
      errors += srpt_grant_top_i.srpt_grant_assert_i.fail_cnt - assert_seen;
      assert_seen = srpt_grant_top_i.srpt_grant_assert_i.fail_cnt;
      if (errors != errs_before) begin
         failed_tests++;
      end
      $display("Test %0d %s, %0d headers, %0d grants", test,
               (errors == errs_before) ? "passed" : "failed", n_rd - rd_start, got_q.size());
   endtask

   initial begin
      ap_rst         = 1'b1;
      header_empty_i = 1'b1;
      header_data_i  = '0;
      grant_full_i   = 1'b0;
      rd_cnt         = 0;
      errors         = 0;
      failed_tests   = 0;
      assert_seen    = 0;
      void'($urandom(32'hdc729478));
      load_table();
      repeat (2) @(posedge ap_clk);
      ap_rst <= 1'b0;
      run_test(1, 1'b0, 1'b0);
      run_test(2, 1'b0, 1'b0);
      run_test(3, 1'b0, 1'b0);
      run_test(4, 1'b1, 1'b0);
      run_test(5, 1'b0, 1'b1);
      $display("Tests run 5, failed %0d, errors %0d", failed_tests, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== srpt_grant_top.sv ====
`timescale 1ns/1ps
`include "srpt_settings.svh"

module srpt_grant_top (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  header_empty_i,
   input  srpt_pkg::srpt_hdr_t   header_data_i,
   output logic                  header_rd_o,
   input  logic                  grant_full_i,
   output logic                  grant_wr_o,
   output srpt_pkg::srpt_entry_t grant_data_o
);

   // Operation shared by both queues
   srpt_pkg::queue_op_e   queue_op;
   // Best entry of the main queue
   srpt_pkg::srpt_entry_t main_head;
   // Grant candidate and worst entry of the active set
   srpt_pkg::srpt_entry_t act_head;
   srpt_pkg::srpt_entry_t act_tail;
   // Entry created from the current header
   srpt_pkg::srpt_entry_t new_entry;

   srpt_grant_ctrl srpt_grant_ctrl_i (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .header_empty_i(header_empty_i),
      .header_data_i (header_data_i),
      .header_rd_o   (header_rd_o),
      .grant_full_i  (grant_full_i),
      .grant_wr_o    (grant_wr_o),
      .grant_data_o  (grant_data_o),
      .main_head_i   (main_head),
      .act_head_i    (act_head),
      .act_tail_i    (act_tail),
      .op_o          (queue_op),
      .new_entry_o   (new_entry)
   );

   // Active tail goes back to the main queue on a promote
   srpt_main_queue #(
      .DEPTH(`SRPT_MAIN_DEPTH)
   ) srpt_main_queue_i (
      .ap_clk  (ap_clk),
      .ap_rst  (ap_rst),
      .op_i    (queue_op),
      .insert_i(new_entry),
      .evict_i (act_tail),
      .head_o  (main_head)
   );

   srpt_active_set #(
      .SLOTS(`SRPT_OVERCOMMIT)
   ) srpt_active_set_i (
      .ap_clk     (ap_clk),
      .ap_rst     (ap_rst),
      .op_i       (queue_op),
      .main_head_i(main_head),
      .head_o     (act_head),
      .tail_o     (act_tail)
   );

endmodule

// ==== srpt_main_queue.sv ====
`timescale 1ns/1ps
`include "srpt_settings.svh"

module srpt_main_queue #(
   parameter int DEPTH = `SRPT_MAIN_DEPTH
) (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  srpt_pkg::queue_op_e   op_i,
   input  srpt_pkg::srpt_entry_t insert_i,
   input  srpt_pkg::srpt_entry_t evict_i,
   output srpt_pkg::srpt_entry_t head_o
);
   import srpt_pkg::*;

   // Queue storage, index 0 is the head
   srpt_entry_t queue_q [DEPTH];

   // Result of one transposition pass over the storage
   srpt_entry_t sorted [DEPTH];

   // Sort phase, low selects the even pass
   logic odd_phase_q;

   // Phase used by the sort stage this cycle
   logic pass_odd;

   // A promote always uses the odd pass
   // because that pass leaves slot 0 free for the evicted entry
   assign pass_odd = (op_i == PROMOTE) ? 1'b1 : odd_phase_q;

   srpt_sort_stage #(
      .N(DEPTH)
   ) sort_stage_i (
      .entries_i  (queue_q),
      .odd_phase_i(pass_odd),
      .entries_o  (sorted)
   );

   // Head is the candidate for the active set
   assign head_o = queue_q[0];

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         odd_phase_q <= 1'b0;
         // All slots start free
         for (int i = 0; i < DEPTH; i++) begin
            queue_q[i] <= EMPTY_ENTRY;
         end
      end else begin
         case (op_i)
            INSERT: begin
               // Shift towards the tail, the deepest entry drops out
               for (int i = 1; i < DEPTH; i++) begin
                  queue_q[i] <= queue_q[i-1];
               end
               queue_q[0] <= insert_i;
            end
            PROMOTE: begin
               // Old head moves to the active set, its evicted tail lands here
               queue_q    <= sorted;
               queue_q[0] <= evict_i;
            end
            default: begin
               // SORT and GRANT cycles run the current phase
               queue_q     <= sorted;
               odd_phase_q <= ~odd_phase_q;
            end
         endcase
      end
   end

endmodule

// ==== srpt_pkg.sv ====
`include "srpt_settings.svh"

package srpt_pkg;

   // Higher code ranks first, so ACTIVE beats EMPTY
   typedef enum logic [`SRPT_STATE_W-1:0] {
      EMPTY  = 3'd4,
      ACTIVE = 3'd6
   } entry_state_e;

   // One queue operation per cycle, shared by both queues
   typedef enum logic [1:0] {
      SORT,
      INSERT,
      PROMOTE,
      GRANT
   } queue_op_e;

   // Controller FSM
   typedef enum logic [1:0] {
      IDLE,
      NEW_HDR,
      QUEUE_SWAP
   } ctrl_state_e;

   // Scheduling entry, 51 bits
   typedef struct packed {
      logic [`SRPT_PEER_W-1:0] peer_id;
      logic [`SRPT_RPC_W-1:0]  rpc_id;
      logic [`SRPT_PKTS_W-1:0] recv_pkts;
      logic [`SRPT_PKTS_W-1:0] grant_pkts;
      entry_state_e            state;
   } srpt_entry_t;

   // Incoming data header, 58 bits
   typedef struct packed {
      logic [`SRPT_PEER_W-1:0] peer_id;
      logic [`SRPT_RPC_W-1:0]  rpc_id;
      logic [`SRPT_PKTS_W-1:0] msg_len;
      logic [`SRPT_PKTS_W-1:0] incoming;
      logic [`SRPT_PKTS_W-1:0] offset;
   } srpt_hdr_t;

   // Value of a free slot
   localparam srpt_entry_t EMPTY_ENTRY = '{peer_id: '0, rpc_id: '0, recv_pkts: '0,
                                          grant_pkts: '0, state: EMPTY};

   // State first, then fewer grantable packets
   function automatic logic ranks_before(input srpt_entry_t a, input srpt_entry_t b);
      if (a.state != b.state) begin
         return a.state > b.state;
      end
      return a.grant_pkts < b.grant_pkts;
   endfunction

endpackage

// ==== srpt_settings.svh ====
`ifndef SRPT_SETTINGS_SVH
`define SRPT_SETTINGS_SVH

// Field widths of an entry and of a message header
// Peer id width
`define SRPT_PEER_W 14

// RPC id width
`define SRPT_RPC_W 14

// Packet counts, used for received, grantable, length, incoming and offset
`define SRPT_PKTS_W 10

// Entry state code
`define SRPT_STATE_W 3

// Queue sizes
// Entries held by the deep main queue
`define SRPT_MAIN_DEPTH 16

// Entries held by the small active set
`define SRPT_OVERCOMMIT 4

`endif

// ==== srpt_sort_stage.sv ====
`timescale 1ns/1ps
`include "srpt_settings.svh"

module srpt_sort_stage #(
   parameter int N = `SRPT_OVERCOMMIT
) (
   input  srpt_pkg::srpt_entry_t entries_i [N],
   input  logic                  odd_phase_i,
   output srpt_pkg::srpt_entry_t entries_o [N]
);
   import srpt_pkg::*;

   // One transposition pass
   // Even phase pairs (0,1) (2,3) ..., odd phase pairs (1,2) (3,4) ...
   // Pairs of one phase never overlap, so every swap reads the unsorted input
   always_comb begin
      // Untouched slots pass straight through
      entries_o = entries_i;
      for (int i = 0; i < N - 1; i++) begin
         // Lower index of the pair must match the phase parity
         if (i[0] == odd_phase_i) begin
            // Better entry moves towards index 0
            if (ranks_before(entries_i[i+1], entries_i[i])) begin
               entries_o[i]   = entries_i[i+1];
               entries_o[i+1] = entries_i[i];
            end
         end
      end
   end

   // Equal entries keep their places
   // so the pass is stable and a sorted array stays unchanged
   // An odd pass leaves slot 0 alone
   // which the main queue relies on when it takes an evicted entry
   // The tail is left alone by an odd pass only when N is even

endmodule
